/* design/i2c_slave_pkg.sv */
/*
 * Shared types and protocol constants for the I2C slave.
 * Every RTL file imports this package with a wildcard in its module header.
 * The testbench uses the same types for the byte streams.
 */
package i2c_slave_pkg;

    // bits per data byte on the wire
    localparam int BYTE_BITS = 8;

    // sda level for acknowledge
    // a released (high) sda in the ack slot is a nack
    localparam logic I2C_ACK = 1'b0;

    // one data byte, msb first on the bus
    typedef logic [BYTE_BITS-1:0] i2c_byte_t;

    // 7-bit device address, without the r/w bit
    typedef logic [6:0] i2c_addr_t;

    // filtered bus state from the line monitor
    // scl and sda are levels, the rest are one-cycle pulses
    typedef struct packed {
        logic scl;
        logic sda;
        logic scl_rise;
        logic scl_fall;
        logic start;
        logic stop;
    } line_events_t;

    // received write byte on the output stream
    // last marks the final byte before a stop or repeated start
    typedef struct packed {
        i2c_byte_t data;
        logic      last;
    } rx_byte_t;

endpackage

/* design/i2c_line_monitor.sv */
/*
 * Glitch filter and event detector for the SCL and SDA inputs.
 * A pin level is taken only after FILTER_LEN equal samples.
 * Produces edge, start and stop pulses one cycle after the filtered level
 * changes, and tracks whether the bus is between a start and a stop.
 */
module i2c_line_monitor
    import i2c_slave_pkg::*;
#(
    parameter int FILTER_LEN = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         scl_i,
    input  logic         sda_i,
    output line_events_t events,
    output logic         bus_active
);

    // index 1 is scl, index 0 is sda
    logic [1:0]                 pins;
    logic [1:0][FILTER_LEN-1:0] samples;
    logic [1:0]                 level;
    logic [1:0]                 level_q;

    // registered event pulses
    logic scl_rise_q;
    logic scl_fall_q;
    logic start_q;
    logic stop_q;

    assign pins = {scl_i, sda_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            // idle bus is high on both lines
            samples    <= '1;
            level      <= '1;
            level_q    <= '1;
            scl_rise_q <= 1'b0;
            scl_fall_q <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
            bus_active <= 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                samples[i] <= {samples[i][FILTER_LEN-2:0], pins[i]};
                // level only moves when the whole window agrees
                if (&samples[i]) begin
                    level[i] <= 1'b1;
                end else if (~|samples[i]) begin
                    level[i] <= 1'b0;
                end
            end
            level_q <= level;

            scl_rise_q <= level[1] && !level_q[1];
            scl_fall_q <= !level[1] && level_q[1];
            // sda moving while scl stays high
            start_q    <= !level[0] && level_q[0] && level[1] && level_q[1];
            stop_q     <= level[0] && !level_q[0] && level[1] && level_q[1];

            if (start_q) begin
                bus_active <= 1'b1;
            end else if (stop_q) begin
                bus_active <= 1'b0;
            end
        end
    end

    always_comb begin
        events.scl      = level[1];
        events.sda      = level[0];
        events.scl_rise = scl_rise_q;
        events.scl_fall = scl_fall_q;
        events.start    = start_q;
        events.stop     = stop_q;
    end

endmodule

/* design/i2c_rx_holdback.sv */
/*
 * One-byte holdback for the write path.
 * A received byte stays held until the next byte, a start or a stop shows
 * whether it was the last one of the write, and then moves to the output
 * register with its last flag. rx_stall tells the engine that the output
 * stream is still occupied so it can stretch SCL.
 */
module i2c_rx_holdback
    import i2c_slave_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_push,
    input  logic      rx_flush,
    input  i2c_byte_t rx_data,
    output logic      rx_stall,
    output rx_byte_t  data_out,
    output logic      data_out_valid,
    input  logic      data_out_ready
);

    // held byte, not yet known to be last or not
    i2c_byte_t held_data;
    logic      held_valid;
    // flushed byte still waiting for a free output
    logic      held_go;

    logic out_free;
    logic release_req;
    logic move;

    // output register is empty or emptying this cycle
    assign out_free = !data_out_valid || data_out_ready;
    assign rx_stall = !out_free;

    assign release_req = rx_push || rx_flush || held_go;
    assign move        = held_valid && release_req && out_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid     <= 1'b0;
            held_go        <= 1'b0;
            data_out_valid <= 1'b0;
        end else begin
            if (data_out_ready) begin
                data_out_valid <= 1'b0;
            end

            // a push proves the held byte is not last
            // a flush or a waiting flush marks it last
            if (move) begin
                data_out_valid <= 1'b1;
                data_out       <= '{data: held_data, last: !rx_push};
            end

            if (rx_push) begin
                held_data  <= rx_data;
                held_valid <= 1'b1;
                held_go    <= 1'b0;
            end else if (move) begin
                held_valid <= 1'b0;
                held_go    <= 1'b0;
            end else if (rx_flush && held_valid) begin
                // output busy, release once it frees
                held_go <= 1'b1;
            end
        end
    end

endmodule

/* design/i2c_slave_engine.sv */
/*
 * Bit-level I2C slave protocol engine.
 * Shifts in the address and r/w bit, acknowledges a masked match,
 * receives write bytes into the holdback and sends read bytes taken
 * from the data_in stream. SCL is held low while the write output is
 * occupied or no read byte is available.
 */
module i2c_slave_engine
    import i2c_slave_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  line_events_t events,
    input  logic         enable,
    input  i2c_addr_t    device_address,
    input  i2c_addr_t    device_address_mask,
    output logic         scl_o,
    output logic         sda_o,
    output logic         rx_push,
    output logic         rx_flush,
    output i2c_byte_t    rx_data,
    input  logic         rx_stall,
    input  i2c_byte_t    data_in,
    input  logic         data_in_valid,
    output logic         data_in_ready,
    output i2c_addr_t    bus_address,
    output logic         bus_addressed
);

    localparam int               CNT_W    = $clog2(BYTE_BITS);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(BYTE_BITS - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDRESS,
        ST_ACK,
        ST_WRITE_WAIT,
        ST_WRITE_SHIFT,
        ST_READ_SHIFT,
        ST_READ_ACK_RELEASE,
        ST_READ_ACK_SAMPLE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] bit_cnt;
    i2c_byte_t        shreg;
    logic             read_mode;
    // read byte loaded into shreg
    logic             tx_loaded;

    logic addr_match;
    logic scl_low_phase;

    // mask bit set means the address bit is compared
    assign addr_match = enable &&
        (((shreg[BYTE_BITS-2:0] ^ device_address) & device_address_mask) == '0);

    // falling edge, or still holding scl low ourselves
    assign scl_low_phase = events.scl_fall || (!scl_o && !events.scl);

    // write byte is complete in shreg when rx_push fires
    assign rx_data = shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            bit_cnt       <= CNT_LOAD;
            read_mode     <= 1'b0;
            tx_loaded     <= 1'b0;
            scl_o         <= 1'b1;
            sda_o         <= 1'b1;
            rx_push       <= 1'b0;
            rx_flush      <= 1'b0;
            data_in_ready <= 1'b0;
            bus_address   <= '0;
            bus_addressed <= 1'b0;
        end else begin
            rx_push  <= 1'b0;
            // start or stop ends any write in progress
            rx_flush <= (events.start || events.stop) && bus_addressed;

            if (events.start) begin
                // start or repeated start, look for our address
                scl_o         <= 1'b1;
                sda_o         <= 1'b1;
                data_in_ready <= 1'b0;
                tx_loaded     <= 1'b0;
                bus_addressed <= 1'b0;
                bit_cnt       <= CNT_LOAD;
                state         <= ST_ADDRESS;
            end else if (events.stop) begin
                scl_o         <= 1'b1;
                sda_o         <= 1'b1;
                data_in_ready <= 1'b0;
                tx_loaded     <= 1'b0;
                bus_addressed <= 1'b0;
                state         <= ST_IDLE;
            end else begin
                case (state)
                    ST_ADDRESS: begin
                        if (events.scl_rise) begin
                            if (bit_cnt != '0) begin
                                shreg   <= {shreg[BYTE_BITS-2:0], events.sda};
                                bit_cnt <= bit_cnt - 1'b1;
                            end else if (addr_match) begin
                                // eighth bit is r/w
                                bus_address   <= shreg[BYTE_BITS-2:0];
                                read_mode     <= events.sda;
                                bus_addressed <= 1'b1;
                                state         <= ST_ACK;
                            end else begin
                                // not for us, wait for the next start
                                state <= ST_IDLE;
                            end
                        end
                    end
                    ST_ACK: begin
                        // ack slot begins on this fall
                        if (events.scl_fall) begin
                            sda_o   <= I2C_ACK;
                            bit_cnt <= CNT_LOAD;
                            if (read_mode) begin
                                data_in_ready <= 1'b1;
                                tx_loaded     <= 1'b0;
                                state         <= ST_READ_SHIFT;
                            end else begin
                                state <= ST_WRITE_WAIT;
                            end
                        end
                    end
                    ST_WRITE_WAIT: begin
                        // end of ack, next write byte begins
                        if (scl_low_phase) begin
                            sda_o <= 1'b1;
                            if (rx_stall) begin
                                scl_o <= 1'b0;
                            end else begin
                                scl_o <= 1'b1;
                                state <= ST_WRITE_SHIFT;
                            end
                        end
                    end
                    ST_WRITE_SHIFT: begin
                        if (events.scl_rise) begin
                            shreg <= {shreg[BYTE_BITS-2:0], events.sda};
                            if (bit_cnt != '0) begin
                                bit_cnt <= bit_cnt - 1'b1;
                            end else begin
                                rx_push <= 1'b1;
                                state   <= ST_ACK;
                            end
                        end
                    end
                    ST_READ_SHIFT: begin
                        // take the next byte from the stream
                        if (data_in_ready && data_in_valid) begin
                            shreg         <= data_in;
                            tx_loaded     <= 1'b1;
                            data_in_ready <= 1'b0;
                        end
                        if (scl_low_phase) begin
                            if (!tx_loaded) begin
                                // no byte yet, stretch
                                scl_o <= 1'b0;
                            end else begin
                                scl_o <= 1'b1;
                                sda_o <= shreg[BYTE_BITS-1];
                                shreg <= {shreg[BYTE_BITS-2:0], 1'b0};
                                if (bit_cnt != '0) begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                end else begin
                                    state <= ST_READ_ACK_RELEASE;
                                end
                            end
                        end
                    end
                    ST_READ_ACK_RELEASE: begin
                        // master owns sda for its ack
                        if (events.scl_fall) begin
                            sda_o <= 1'b1;
                            state <= ST_READ_ACK_SAMPLE;
                        end
                    end
                    ST_READ_ACK_SAMPLE: begin
                        if (events.scl_rise) begin
                            if (events.sda != I2C_ACK) begin
                                // nack ends the read
                                bus_addressed <= 1'b0;
                                state         <= ST_IDLE;
                            end else begin
                                bit_cnt       <= CNT_LOAD;
                                data_in_ready <= 1'b1;
                                tx_loaded     <= 1'b0;
                                state         <= ST_READ_SHIFT;
                            end
                        end
                    end
                    default: begin
                        // idle until a start
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* design/i2c_slave_top.sv */
/*
 * I2C slave top level.
 * Write bytes leave on the data_out stream with a last flag, read bytes
 * are taken from the data_in stream. The bus pins are open-drain style,
 * an output of 0 pulls the line low; connect them through AND logic or a
 * tristate pad, never scl_o straight to scl_i.
 */
module i2c_slave_top
    import i2c_slave_pkg::*;
#(
    parameter int FILTER_LEN = 4
) (
    input  logic      clk,
    input  logic      rst,
    // bus
    input  logic      scl_i,
    input  logic      sda_i,
    output logic      scl_o,
    output logic      sda_o,
    // write stream out
    output rx_byte_t  data_out,
    output logic      data_out_valid,
    input  logic      data_out_ready,
    // read stream in
    input  i2c_byte_t data_in,
    input  logic      data_in_valid,
    output logic      data_in_ready,
    // configuration
    input  logic      enable,
    input  i2c_addr_t device_address,
    input  i2c_addr_t device_address_mask,
    // status
    output i2c_addr_t bus_address,
    output logic      bus_addressed,
    output logic      bus_active
);

    line_events_t events;
    logic         rx_push;
    logic         rx_flush;
    logic         rx_stall;
    i2c_byte_t    rx_data;

    i2c_line_monitor #(
        .FILTER_LEN (FILTER_LEN)
    ) u_line_monitor (
        .clk        (clk),
        .rst        (rst),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .events     (events),
        .bus_active (bus_active)
    );

    i2c_rx_holdback u_rx_holdback (
        .clk            (clk),
        .rst            (rst),
        .rx_push        (rx_push),
        .rx_flush       (rx_flush),
        .rx_data        (rx_data),
        .rx_stall       (rx_stall),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    i2c_slave_engine u_engine (
        .clk                 (clk),
        .rst                 (rst),
        .events              (events),
        .enable              (enable),
        .device_address      (device_address),
        .device_address_mask (device_address_mask),
        .scl_o               (scl_o),
        .sda_o               (sda_o),
        .rx_push             (rx_push),
        .rx_flush            (rx_flush),
        .rx_data             (rx_data),
        .rx_stall            (rx_stall),
        .data_in             (data_in),
        .data_in_valid       (data_in_valid),
        .data_in_ready       (data_in_ready),
        .bus_address         (bus_address),
        .bus_addressed       (bus_addressed)
    );

endmodule

/* test/i2c_slave_assertions.sv */
/*
 * Concurrent checks on the I2C slave top level.
 * Bound to every i2c_slave_top instance by the bind below; covers the
 * valid/ready stream rules, output values in reset and a few status
 * relations. The testbench reads fail_count at the end of the run.
 */
module i2c_slave_checks
    import i2c_slave_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      scl_o,
    input logic      sda_o,
    input rx_byte_t  data_out,
    input logic      data_out_valid,
    input logic      data_out_ready,
    input i2c_byte_t data_in,
    input logic      data_in_valid,
    input logic      data_in_ready,
    input logic      bus_addressed,
    input logic      bus_active
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // write stream holds its byte until taken
    out_stable: assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
    else begin
        $error("data_out changed or lost valid before ready");
        fail_count++;
    end

    // same rule on the read stream source
    in_stable: assert property (@(posedge clk) disable iff (rst)
        data_in_valid && !data_in_ready |=> data_in_valid && $stable(data_in))
    else begin
        $error("data_in changed or lost valid before ready");
        fail_count++;
    end

    // bus released and streams idle once reset has been applied
    reset_outputs: assert property (@(posedge clk)
        rst |=> scl_o && sda_o && !data_out_valid && !data_in_ready)
    else begin
        $error("bus or stream outputs active during reset");
        fail_count++;
    end

    reset_status: assert property (@(posedge clk)
        rst |=> !bus_addressed && !bus_active)
    else begin
        $error("status outputs set during reset");
        fail_count++;
    end

    // addressed only inside a start..stop window
    addressed_active: assert property (@(posedge clk) disable iff (rst)
        bus_addressed |-> bus_active)
    else begin
        $error("bus_addressed high outside an active bus");
        fail_count++;
    end

    // stretching only while addressed
    stretch_addressed: assert property (@(posedge clk) disable iff (rst)
        !scl_o |-> bus_addressed)
    else begin
        $error("scl held low while not addressed");
        fail_count++;
    end

endmodule

bind i2c_slave_top i2c_slave_checks checks (
    .clk            (clk),
    .rst            (rst),
    .scl_o          (scl_o),
    .sda_o          (sda_o),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .bus_addressed  (bus_addressed),
    .bus_active     (bus_active)
);

/* test/tb_i2c_slave.sv */
/*
 * Testbench for the I2C slave top level.
 * A master model drives the open-drain bus at 40 clocks per bit, a
 * receiver drains data_out with random ready and a driver offers data_in
 * bytes from a queue. Bound assertions watch the stream and reset rules.
 */
module tb_i2c_slave
    import i2c_slave_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int        FILTER_LEN = 4;
    // a quarter bit has to outlast filter, event and engine delay
    localparam int        QUARTER    = FILTER_LEN + 6;
    localparam int        BIT_CLKS   = 4 * QUARTER;
    // start, address, payload and stop bits of the five tests
    localparam int        TOTAL_BITS = 38 + 33 + 29 + 38 + 48;
    localparam i2c_addr_t DEV_ADDR   = 7'h42;

    logic      clk;
    logic      rst;
    logic      m_scl;
    logic      m_sda;
    logic      scl;
    logic      sda;
    logic      scl_o;
    logic      sda_o;
    rx_byte_t  data_out;
    logic      data_out_valid;
    logic      data_out_ready;
    i2c_byte_t data_in;
    logic      data_in_valid;
    logic      data_in_ready;
    logic      enable;
    i2c_addr_t device_address;
    i2c_addr_t device_address_mask;
    i2c_addr_t bus_address;
    logic      bus_addressed;
    logic      bus_active;

    logic      hold_ready;
    int        errors = 0;
    rx_byte_t  exp_out[$];
    i2c_byte_t tx_bytes[$];

    // wired-and bus lines
    assign scl = m_scl & scl_o;
    assign sda = m_sda & sda_o;

    i2c_slave_top #(
        .FILTER_LEN (FILTER_LEN)
    ) dut (
        .clk                 (clk),
        .rst                 (rst),
        .scl_i               (scl),
        .sda_i               (sda),
        .scl_o               (scl_o),
        .sda_o               (sda_o),
        .data_out            (data_out),
        .data_out_valid      (data_out_valid),
        .data_out_ready      (data_out_ready),
        .data_in             (data_in),
        .data_in_valid       (data_in_valid),
        .data_in_ready       (data_in_ready),
        .enable              (enable),
        .device_address      (device_address),
        .device_address_mask (device_address_mask),
        .bus_address         (bus_address),
        .bus_addressed       (bus_addressed),
        .bus_active          (bus_active)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // wait n edges and land just after the last one
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // one scl period with sda set mid low phase and sampled mid high phase
    task automatic clock_bit(input logic b, output logic got);
        m_scl = 1'b0;
        step(QUARTER);
        m_sda = b;
        step(QUARTER);
        m_scl = 1'b1;
        // slave may be stretching
        while (scl_o !== 1'b1) step(1);
        step(QUARTER);
        got = sda;
        step(QUARTER);
    endtask

    // also used as repeated start
    task automatic bus_start();
        m_scl = 1'b0;
        step(QUARTER);
        m_sda = 1'b1;
        step(QUARTER);
        m_scl = 1'b1;
        while (scl_o !== 1'b1) step(1);
        step(QUARTER);
        m_sda = 1'b0;
        step(QUARTER);
        check_value("bus_active", 32'(bus_active), 1);
    endtask

    task automatic bus_stop();
        m_scl = 1'b0;
        step(QUARTER);
        m_sda = 1'b0;
        step(QUARTER);
        m_scl = 1'b1;
        while (scl_o !== 1'b1) step(1);
        step(QUARTER);
        m_sda = 1'b1;
        step(QUARTER);
        check_value("bus_active", 32'(bus_active), 0);
    endtask

    task automatic send_byte(input i2c_byte_t b, input logic exp_ack);
        logic got;
        for (int i = BYTE_BITS - 1; i >= 0; i--) begin
            clock_bit(b[i], got);
        end
        // released sda in the ack slot
        clock_bit(1'b1, got);
        check_value("sda ack", 32'(got), 32'(exp_ack));
    endtask

    task automatic recv_byte(input i2c_byte_t exp, input logic ack);
        i2c_byte_t b;
        logic      got;
        for (int i = BYTE_BITS - 1; i >= 0; i--) begin
            clock_bit(1'b1, got);
            b[i] = got;
        end
        clock_bit(ack, got);
        check_value("read byte", 32'(b), 32'(exp));
    endtask

    // random write bytes with last expected on the final one
    task automatic write_payload(input int count);
        i2c_byte_t b;
        rx_byte_t  e;
        for (int i = 0; i < count; i++) begin
            b = i2c_byte_t'($urandom);
            e.data = b;
            e.last = (i == count - 1);
            exp_out.push_back(e);
            send_byte(b, I2C_ACK);
        end
    endtask

    // write stream sink that compares in the cycle before the handshake edge
    initial begin : write_stream_receiver
        rx_byte_t e;
        data_out_ready = 1'b0;
        forever begin
            step(1);
            data_out_ready = !hold_ready && (($urandom % 4) != 0);
            if (data_out_valid && data_out_ready) begin
                if (exp_out.size() == 0) begin
                    $display("data_out delivered byte %h that was never written at %0t",
                             data_out.data, $time);
                    errors++;
                end else begin
                    e = exp_out.pop_front();
                    check_value("data_out.data", 32'(data_out.data), 32'(e.data));
                    check_value("data_out.last", 32'(data_out.last), 32'(e.last));
                end
            end
        end
    end

    // read stream source
    initial begin : read_stream_driver
        logic taken;
        taken         = 1'b0;
        data_in       = '0;
        data_in_valid = 1'b0;
        forever begin
            step(1);
            if (taken) begin
                data_in_valid = 1'b0;
            end
            if (!data_in_valid && tx_bytes.size() > 0) begin
                data_in       = tx_bytes.pop_front();
                data_in_valid = 1'b1;
            end
            taken = data_in_valid && data_in_ready;
        end
    end

    initial begin : watchdog
        repeat (TOTAL_BITS * BIT_CLKS * 4) @(posedge clk);
        $display("timeout: tests did not finish, %0d errors so far", errors);
        $display("Verification failed");
        $finish;
    end

    initial begin : test_sequence
        i2c_byte_t b;
        void'($urandom(94));
        rst                 = 1'b1;
        m_scl               = 1'b1;
        m_sda               = 1'b1;
        enable              = 1'b1;
        device_address      = DEV_ADDR;
        device_address_mask = 7'h7F;
        hold_ready          = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        step(BIT_CLKS);

        // three byte write
        bus_start();
        send_byte({DEV_ADDR, 1'b0}, I2C_ACK);
        write_payload(3);
        bus_stop();
        step(2 * QUARTER);

        // bit 0 masked out so still ours
        device_address_mask = 7'h7E;
        bus_start();
        send_byte({DEV_ADDR ^ 7'h01, 1'b0}, I2C_ACK);
        check_value("bus_addressed", 32'(bus_addressed), 1);
        check_value("bus_address", 32'(bus_address), 32'(DEV_ADDR ^ 7'h01));
        bus_stop();
        // compared bit differs
        bus_start();
        send_byte({DEV_ADDR ^ 7'h10, 1'b0}, 1'b1);
        check_value("bus_addressed", 32'(bus_addressed), 0);
        bus_stop();
        // disabled slave ignores its own address
        enable = 1'b0;
        bus_start();
        send_byte({DEV_ADDR, 1'b0}, 1'b1);
        check_value("bus_addressed", 32'(bus_addressed), 0);
        bus_stop();
        enable              = 1'b1;
        device_address_mask = 7'h7F;
        step(2 * QUARTER);

        // two byte read with a nack on the second
        tx_bytes.push_back(8'hA5);
        tx_bytes.push_back(8'h3C);
        bus_start();
        send_byte({DEV_ADDR, 1'b1}, I2C_ACK);
        recv_byte(8'hA5, I2C_ACK);
        recv_byte(8'h3C, !I2C_ACK);
        check_value("data_in_ready", 32'(data_in_ready), 0);
        check_value("bus_addressed", 32'(bus_addressed), 0);
        bus_stop();
        check_value("data_in_ready", 32'(data_in_ready), 0);
        step(2 * QUARTER);

        // blocked write stream makes the third byte start stretch
        hold_ready = 1'b1;
        fork
            begin
                bus_start();
                send_byte({DEV_ADDR, 1'b0}, I2C_ACK);
                write_payload(3);
            end
            begin : stretch_watch
                int waited;
                waited = 0;
                while (scl_o === 1'b1 && waited < 40 * BIT_CLKS) begin
                    step(1);
                    waited++;
                end
                if (scl_o !== 1'b0) begin
                    $display("SCL was never stretched while data_out_ready was held low");
                    errors++;
                end
                step(100);
                hold_ready = 1'b0;
            end
        join
        bus_stop();
        step(2 * QUARTER);

        // write, repeated start, read
        bus_start();
        send_byte({DEV_ADDR, 1'b0}, I2C_ACK);
        write_payload(2);
        b = i2c_byte_t'($urandom);
        tx_bytes.push_back(b);
        bus_start();
        send_byte({DEV_ADDR, 1'b1}, I2C_ACK);
        // last write byte already out before read data
        check_value("pending data_out bytes", exp_out.size(), 0);
        recv_byte(b, !I2C_ACK);
        bus_stop();

        step(4 * BIT_CLKS);
        check_value("pending data_out bytes", exp_out.size(), 0);
        $display("run complete: %0d errors, %0d assertion failures",
                 errors, dut.checks.fail_count);
        if (errors == 0 && dut.checks.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sources.f */
design/i2c_slave_pkg.sv
design/i2c_line_monitor.sv
design/i2c_rx_holdback.sv
design/i2c_slave_engine.sv
design/i2c_slave_top.sv
test/i2c_slave_assertions.sv
test/tb_i2c_slave.sv

/* Makefile */
# Verilator build and run of the I2C slave testbench
# override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_i2c_slave
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?=
PASS_MSG  ?= Verification passed

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard design/*.sv test/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
